// File: source/ts_geom_pkg.sv
`default_nettype none

package ts_geom_pkg;

	// video line number and screen coordinate
	localparam int LINE_W = 9;

	// descriptor file words
	localparam int WORD_W = 16;
	localparam int SFILE_AW = 8;
	localparam int DESC_WORDS = 3;

	// field widths
	localparam int SZ_W = 3;
	localparam int TNUM_W = 12;
	localparam int PAL_W = 4;
	localparam int ADDR_W = 6;
	// 8 pixel cells, size field counts cells minus one
	localparam int CELL_SH = 3;
	localparam int YMAX_W = SZ_W + CELL_SH;

	// word 0 layout
	localparam int W0_YCRD_POS = 0;
	localparam int W0_YSZ_POS = 9;
	localparam int W0_ACT_POS = 13;
	localparam int W0_YFLP_POS = 15;

	// word 1 layout
	localparam int W1_XCRD_POS = 0;
	localparam int W1_XSZ_POS = 9;
	localparam int W1_XFLP_POS = 15;

	// word 2 layout
	localparam int W2_TNUM_POS = 0;
	localparam int W2_PAL_POS = 12;

endpackage

`default_nettype wire

// File: source/ts_task_pkg.sv
`default_nettype none

package ts_task_pkg;

	import ts_geom_pkg::*;

	// decoded sprite descriptor
	typedef struct packed {
		logic [LINE_W-1:0] ycrd;
		logic [SZ_W-1:0] ysz;
		logic act;
		logic yflp;
		logic [LINE_W-1:0] xcrd;
		logic [SZ_W-1:0] xsz;
		logic xflp;
		logic [TNUM_W-1:0] tnum;
		logic [PAL_W-1:0] pal;
	} sprite_desc_t;

	// one job for the line renderer
	typedef struct packed {
		logic [LINE_W-1:0] x;
		logic [SZ_W-1:0] xs;
		logic xf;
		// bitmap line within graphics page
		logic [LINE_W-1:0] line;
		// word within bitmap line
		logic [ADDR_W-1:0] addr;
		logic [PAL_W-1:0] pal;
	} sprite_task_t;

	// raw words to fields
	function automatic sprite_desc_t desc_decode(
		input logic [WORD_W-1:0] w0,
		input logic [WORD_W-1:0] w1,
		input logic [WORD_W-1:0] w2
	);
		sprite_desc_t d;
		d.ycrd = w0[W0_YCRD_POS +: LINE_W];
		d.ysz = w0[W0_YSZ_POS +: SZ_W];
		d.act = w0[W0_ACT_POS];
		d.yflp = w0[W0_YFLP_POS];
		d.xcrd = w1[W1_XCRD_POS +: LINE_W];
		d.xsz = w1[W1_XSZ_POS +: SZ_W];
		d.xflp = w1[W1_XFLP_POS];
		d.tnum = w2[W2_TNUM_POS +: TNUM_W];
		d.pal = w2[W2_PAL_POS +: PAL_W];
		return d;
	endfunction

endpackage

`default_nettype wire

// File: source/sprite_lane_if.sv
`timescale 1ns/1ps
`default_nettype none

interface sprite_lane_if
	import ts_geom_pkg::*, ts_task_pkg::*;
();

	// group strobe, same cycle in all lanes
	logic load;
	// descriptor of this lane's sprite
	sprite_desc_t desc;
	// line latched at scan start
	logic [LINE_W-1:0] line;

	// lane result
	logic hit;
	sprite_task_t tsk;

	// issuer consumed the task
	logic take;

	// descriptor file side
	modport reader (
		output load,
		output desc,
		output line
	);

	// issuer side
	// load tells the issuer that a fresh group sits in the lanes
	modport issuer (
		input load,
		input hit,
		input tsk,
		output take
	);

	// evaluator side
	modport lane (
		input load,
		input desc,
		input take,
		output hit,
		output tsk
	);

endinterface

`default_nettype wire

// File: source/sprite_desc_file.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_desc_file
	import ts_geom_pkg::*, ts_task_pkg::*;
#(
	parameter int NUM_SPR = 64,
	parameter int LANES = 4
)(
	input logic clk,
	input logic rst,
	input logic start,
	input logic [LINE_W-1:0] line,
	input logic [SFILE_AW-1:0] sfile_addr,
	input logic [WORD_W-1:0] sfile_data,
	input logic sfile_we,
	input logic group_done,
	output logic scan_done,
	sprite_lane_if.reader lanes [LANES]
);

	localparam int GRPS = NUM_SPR / LANES;
	localparam int ROWS = GRPS * DESC_WORDS;
	localparam int RW = (ROWS > 1) ? $clog2(ROWS) : 1;
	localparam int GW = (GRPS > 1) ? $clog2(GRPS) : 1;
	localparam int PH_W = $clog2(DESC_WORDS + 1);

	// read sequencer
	logic busy;
	logic [PH_W-1:0] ph;
	logic [GW-1:0] grp;
	// group handed to lanes, issuer not done yet
	logic outst;
	logic group_load;
	logic rd_en;
	logic [RW-1:0] rd_row;
	logic [LINE_W-1:0] line_r;

	// cpu write decode
	logic [SFILE_AW-1:0] wr_spr;
	logic [SFILE_AW-1:0] wr_word;
	logic [SFILE_AW-1:0] wr_bank;
	logic [SFILE_AW-1:0] wr_grp;
	logic [RW-1:0] wr_row;
	logic wr_ok;

	// word 3k+j of sprite k, sprite k in bank k mod LANES
	always_comb
	begin
		wr_spr = sfile_addr / SFILE_AW'(DESC_WORDS);
		wr_word = sfile_addr % SFILE_AW'(DESC_WORDS);
		wr_bank = wr_spr % SFILE_AW'(LANES);
		wr_grp = wr_spr / SFILE_AW'(LANES);
		wr_row = RW'(wr_grp) * RW'(DESC_WORDS) + RW'(wr_word);
		wr_ok = sfile_we && (wr_spr < SFILE_AW'(NUM_SPR));
	end

	// one word per bank per cycle, last phase holds word 2 on rd_q
	assign rd_en = busy && (ph < PH_W'(DESC_WORDS));
	assign rd_row = RW'(grp) * RW'(DESC_WORDS) + RW'(ph);
	assign group_load = busy && (ph == PH_W'(DESC_WORDS));

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			ph <= '0;
			grp <= '0;
			outst <= 1'b0;
			scan_done <= 1'b0;
		end
		else
		begin
			scan_done <= 1'b0;
			if (start)
			begin
				// restart from group 0 even mid scan
				busy <= 1'b1;
				ph <= '0;
				grp <= '0;
				outst <= 1'b0;
			end
			else if (busy)
			begin
				if (group_load)
				begin
					busy <= 1'b0;
					ph <= '0;
					outst <= 1'b1;
				end
				else
					ph <= ph + 1'b1;
			end
			else if (outst && group_done)
			begin
				outst <= 1'b0;
				if (grp == GW'(GRPS - 1))
					scan_done <= 1'b1;
				else
				begin
					// next group request
					grp <= grp + 1'b1;
					busy <= 1'b1;
				end
			end
		end
	end

	// line held for the whole scan
	always_ff @(posedge clk)
		if (start)
			line_r <= line;

	genvar g;
	generate
		for (g = 0; g < LANES; g++)
		begin : g_bank
			logic [WORD_W-1:0] mem [ROWS];
			logic [WORD_W-1:0] rd_q;
			logic [WORD_W-1:0] w0_r;
			logic [WORD_W-1:0] w1_r;

			always_ff @(posedge clk)
			begin
				if (wr_ok && (wr_bank == SFILE_AW'(g)))
					mem[wr_row] <= sfile_data;
				if (rd_en)
					rd_q <= mem[rd_row];
			end

			// words 0 and 1 parked while word 2 is read
			always_ff @(posedge clk)
			begin
				if (busy && (ph == PH_W'(1)))
					w0_r <= rd_q;
				if (busy && (ph == PH_W'(2)))
					w1_r <= rd_q;
			end

			assign lanes[g].load = group_load;
			assign lanes[g].desc = desc_decode(w0_r, w1_r, rd_q);
			assign lanes[g].line = line_r;
		end
	endgenerate

	// a group goes out only after the issuer released the previous one
	a_no_overlap: assert property (@(posedge clk) disable iff (rst)
		group_load |-> !outst);

	// issuer only finishes groups that were delivered
	a_done_known: assert property (@(posedge clk) disable iff (rst || start)
		group_done |-> outst);

endmodule

`default_nettype wire

// File: source/sprite_lane.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_lane
	import ts_geom_pkg::*, ts_task_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic [LINE_W-1:0] line,
	sprite_lane_if.lane lane
);

	// line inside sprite, modulo 512 so sprites wrap past line 511
	logic [LINE_W-1:0] offs;
	// last covered line of the sprite
	logic [YMAX_W-1:0] ymax;
	logic [YMAX_W-1:0] bm_offs;
	logic [LINE_W-1:0] bm_base;
	logic vis;

	logic hit_r;
	sprite_task_t tsk_r;

	always_comb
	begin
		offs = line - lane.desc.ycrd;
		ymax = {lane.desc.ysz, {CELL_SH{1'b1}}};
		vis = lane.desc.act && (offs <= LINE_W'(ymax));
		// y flip mirrors within the sprite height
		if (lane.desc.yflp)
			bm_offs = ymax - offs[YMAX_W-1:0];
		else
			bm_offs = offs[YMAX_W-1:0];
		// upper tile bits select the bitmap row of 8 lines
		bm_base = {lane.desc.tnum[TNUM_W-1:ADDR_W], {CELL_SH{1'b0}}};
	end

	// hit valid one cycle after load
	// take clears it once the renderer got the task
	always_ff @(posedge clk)
	begin
		if (rst)
			hit_r <= 1'b0;
		else if (lane.load)
			hit_r <= vis;
		else if (lane.take)
			hit_r <= 1'b0;
	end

	// task fields, only meaningful with hit
	always_ff @(posedge clk)
	begin
		if (lane.load)
		begin
			tsk_r.x <= lane.desc.xcrd;
			tsk_r.xs <= lane.desc.xsz;
			tsk_r.xf <= lane.desc.xflp;
			tsk_r.line <= bm_base + LINE_W'(bm_offs);
			tsk_r.addr <= lane.desc.tnum[ADDR_W-1:0];
			tsk_r.pal <= lane.desc.pal;
		end
	end

	assign lane.hit = hit_r;
	assign lane.tsk = tsk_r;

	// issuer never takes an empty lane
	a_take_hit: assert property (@(posedge clk) disable iff (rst)
		lane.take |-> lane.hit);

endmodule

`default_nettype wire

// File: source/sprite_task_issuer.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_task_issuer
	import ts_geom_pkg::*, ts_task_pkg::*;
#(
	parameter int NUM_SPR = 64,
	parameter int LANES = 4
)(
	input logic clk,
	input logic rst,
	input logic start,
	input logic tsr_rdy,
	sprite_lane_if.issuer lanes [LANES],
	output logic group_done,
	output logic tsr_go,
	output logic [LINE_W-1:0] tsr_x,
	output logic [SZ_W-1:0] tsr_xs,
	output logic tsr_xf,
	output logic [LINE_W-1:0] tsr_line,
	output logic [ADDR_W-1:0] tsr_addr,
	output logic [PAL_W-1:0] tsr_pal
);

	localparam int PW = (LANES > 1) ? $clog2(LANES) : 1;

	// lane results gathered for indexing by the pointer
	logic [LANES-1:0] hit_v;
	logic [LANES-1:0] take_v;
	sprite_task_t tsk_v [LANES];

	logic grp_load;
	logic busy;
	logic [PW-1:0] ptr;
	logic cur_hit;
	sprite_task_t cur_tsk;
	// pointer moves on
	logic step;

	genvar g;
	generate
		for (g = 0; g < LANES; g++)
		begin : g_lane
			assign hit_v[g] = lanes[g].hit;
			assign tsk_v[g] = lanes[g].tsk;
			assign take_v[g] = tsr_go && (ptr == PW'(g));
			assign lanes[g].take = take_v[g];
		end
	endgenerate

	// all lanes load together
	assign grp_load = lanes[0].load;

	assign cur_hit = hit_v[ptr];
	assign cur_tsk = tsk_v[ptr];

	// empty lane skipped in one cycle while a hit lane waits for the renderer
	assign tsr_go = busy && cur_hit && tsr_rdy;
	assign step = busy && (!cur_hit || tsr_rdy);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			ptr <= '0;
			group_done <= 1'b0;
		end
		else
		begin
			group_done <= 1'b0;
			if (start)
			begin
				// drop whatever group was in flight
				busy <= 1'b0;
				ptr <= '0;
			end
			else if (grp_load)
			begin
				busy <= 1'b1;
				ptr <= '0;
			end
			else if (step)
			begin
				if (ptr == PW'(LANES - 1))
				begin
					busy <= 1'b0;
					group_done <= 1'b1;
				end
				else
					ptr <= ptr + 1'b1;
			end
		end
	end

	// renderer task from the lane under the pointer
	assign tsr_x = cur_tsk.x;
	assign tsr_xs = cur_tsk.xs;
	assign tsr_xf = cur_tsk.xf;
	assign tsr_line = cur_tsk.line;
	assign tsr_addr = cur_tsk.addr;
	assign tsr_pal = cur_tsk.pal;

	// renderer accepts a task only when ready
	a_go_rdy: assert property (@(posedge clk) disable iff (rst)
		tsr_go |-> tsr_rdy);

endmodule

`default_nettype wire

// File: source/sprite_scan_top.sv
`timescale 1ns/1ps
`default_nettype none

module sprite_scan_top
	import ts_geom_pkg::*;
#(
	parameter int NUM_SPR = 64,
	parameter int LANES = 4
)(
	input logic clk,
	input logic rst,
	input logic start,
	input logic [LINE_W-1:0] line,
	input logic [SFILE_AW-1:0] sfile_addr,
	input logic [WORD_W-1:0] sfile_data,
	input logic sfile_we,
	input logic tsr_rdy,
	output logic tsr_go,
	output logic [LINE_W-1:0] tsr_x,
	output logic [SZ_W-1:0] tsr_xs,
	output logic tsr_xf,
	output logic [LINE_W-1:0] tsr_line,
	output logic [ADDR_W-1:0] tsr_addr,
	output logic [PAL_W-1:0] tsr_pal,
	output logic scan_done
);

	// one bus per lane
	sprite_lane_if lane_bus [LANES] ();

	// issuer released the current group
	logic group_done;

	sprite_desc_file #(
		.NUM_SPR (NUM_SPR),
		.LANES (LANES)
	) u_desc_file (
		.clk (clk),
		.rst (rst),
		.start (start),
		.line (line),
		.sfile_addr (sfile_addr),
		.sfile_data (sfile_data),
		.sfile_we (sfile_we),
		.group_done (group_done),
		.scan_done (scan_done),
		.lanes (lane_bus)
	);

	// lane evaluators, line comes latched from the descriptor file
	genvar g;
	generate
		for (g = 0; g < LANES; g++)
		begin : g_lane
			sprite_lane u_lane (
				.clk (clk),
				.rst (rst),
				.line (lane_bus[g].line),
				.lane (lane_bus[g])
			);
		end
	endgenerate

	sprite_task_issuer #(
		.NUM_SPR (NUM_SPR),
		.LANES (LANES)
	) u_issuer (
		.clk (clk),
		.rst (rst),
		.start (start),
		.tsr_rdy (tsr_rdy),
		.lanes (lane_bus),
		.group_done (group_done),
		.tsr_go (tsr_go),
		.tsr_x (tsr_x),
		.tsr_xs (tsr_xs),
		.tsr_xf (tsr_xf),
		.tsr_line (tsr_line),
		.tsr_addr (tsr_addr),
		.tsr_pal (tsr_pal)
	);

endmodule

`default_nettype wire

// File: dv/tb_sprite_scan.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sprite_scan
	import ts_geom_pkg::*, ts_task_pkg::*;
();

	localparam int NUM_SPR = 64;
	localparam int LANES = 4;
	localparam int N_SCEN = 7;
	// sprite slots per table entry
	// unused slots hold index -1
	localparam int SLOTS = 5;
	// stalls and lane drain on top of the descriptor writes
	localparam int STALL_MARGIN = NUM_SPR * 5;
	localparam int LIMIT = N_SCEN * (NUM_SPR * DESC_WORDS + STALL_MARGIN);

	logic clk;
	logic rst;
	logic start;
	logic [LINE_W-1:0] line;
	logic [SFILE_AW-1:0] sfile_addr;
	logic [WORD_W-1:0] sfile_data;
	logic sfile_we;
	logic tsr_rdy;
	logic tsr_go;
	logic [LINE_W-1:0] tsr_x;
	logic [SZ_W-1:0] tsr_xs;
	logic tsr_xf;
	logic [LINE_W-1:0] tsr_line;
	logic [ADDR_W-1:0] tsr_addr;
	logic [PAL_W-1:0] tsr_pal;
	logic scan_done;

	// scenario table
	int spr_idx [N_SCEN][SLOTS];
	sprite_desc_t spr_desc [N_SCEN][SLOTS];
	int scen_line [N_SCEN];
	int scen_rdy [N_SCEN];

	// renderer always ready in mode 0 and stalling at random in mode 1
	int rdy_mode;
	integer seed;
	logic [31:0] rnd;
	int errors;
	int checks;
	int cycles;
	int done_cnt;
	logic done_seen;
	sprite_task_t got_q [$];
	sprite_task_t mon_t;

	sprite_scan_top #(
		.NUM_SPR (NUM_SPR),
		.LANES (LANES)
	) u_sprite_scan_top (
		.clk (clk),
		.rst (rst),
		.start (start),
		.line (line),
		.sfile_addr (sfile_addr),
		.sfile_data (sfile_data),
		.sfile_we (sfile_we),
		.tsr_rdy (tsr_rdy),
		.tsr_go (tsr_go),
		.tsr_x (tsr_x),
		.tsr_xs (tsr_xs),
		.tsr_xf (tsr_xf),
		.tsr_line (tsr_line),
		.tsr_addr (tsr_addr),
		.tsr_pal (tsr_pal),
		.scan_done (scan_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_equal(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	function automatic sprite_desc_t mk_desc(input int ycrd, input int ysz, input int act,
		input int yflp, input int xcrd, input int xsz, input int xflp, input int tnum,
		input int pal);
		sprite_desc_t d;
		d.ycrd = LINE_W'(ycrd);
		d.ysz = SZ_W'(ysz);
		d.act = act[0];
		d.yflp = yflp[0];
		d.xcrd = LINE_W'(xcrd);
		d.xsz = SZ_W'(xsz);
		d.xflp = xflp[0];
		d.tnum = TNUM_W'(tnum);
		d.pal = PAL_W'(pal);
		return d;
	endfunction

	task automatic set_slot(input int s, input int slot, input int idx, input sprite_desc_t d);
		spr_idx[s][slot] = idx;
		spr_desc[s][slot] = d;
	endtask

	// cpu side word layout
	function automatic logic [WORD_W-1:0] word_of(input sprite_desc_t d, input int j);
		logic [WORD_W-1:0] w;
		w = '0;
		if (j == 0)
		begin
			w[W0_YCRD_POS +: LINE_W] = d.ycrd;
			w[W0_YSZ_POS +: SZ_W] = d.ysz;
			w[W0_ACT_POS] = d.act;
			w[W0_YFLP_POS] = d.yflp;
		end
		else if (j == 1)
		begin
			w[W1_XCRD_POS +: LINE_W] = d.xcrd;
			w[W1_XSZ_POS +: SZ_W] = d.xsz;
			w[W1_XFLP_POS] = d.xflp;
		end
		else
		begin
			w[W2_TNUM_POS +: TNUM_W] = d.tnum;
			w[W2_PAL_POS +: PAL_W] = d.pal;
		end
		return w;
	endfunction

	// sprites not in the entry stay inactive
	function automatic sprite_desc_t desc_for(input int s, input int k);
		sprite_desc_t d;
		int i;
		d = '0;
		for (i = 0; i < SLOTS; i++)
			if (spr_idx[s][i] == k)
				d = spr_desc[s][i];
		return d;
	endfunction

	// reference model of one lane with offset modulo 512 and flip within the height
	function automatic logic model_task(input sprite_desc_t d, input int ln,
		output sprite_task_t t);
		int offs;
		int ymax;
		int bl;
		offs = (ln - int'(d.ycrd) + 512) % 512;
		ymax = int'(d.ysz) * 8 + 7;
		if (d.yflp)
			bl = int'(d.tnum[11:6]) * 8 + ymax - offs;
		else
			bl = int'(d.tnum[11:6]) * 8 + offs;
		t.x = d.xcrd;
		t.xs = d.xsz;
		t.xf = d.xflp;
		t.line = LINE_W'(bl % 512);
		t.addr = d.tnum[5:0];
		t.pal = d.pal;
		return d.act && (offs <= ymax);
	endfunction

	task automatic build_table();
		int s;
		int i;
		for (s = 0; s < N_SCEN; s++)
			for (i = 0; i < SLOTS; i++)
				spr_idx[s][i] = -1;
		// single visible sprite
		set_slot(0, 0, 5, mk_desc(100, 1, 1, 0, 200, 2, 1, 12'h2C5, 3));
		// one inactive sprite and two that just miss the line above and below
		set_slot(1, 0, 2, mk_desc(55, 0, 0, 0, 10, 0, 0, 12'h040, 1));
		set_slot(1, 1, 9, mk_desc(50, 0, 1, 0, 20, 1, 0, 12'h081, 2));
		set_slot(1, 2, 10, mk_desc(59, 0, 1, 0, 30, 0, 0, 12'h0C2, 4));
		// y flip at first and last covered line
		set_slot(2, 0, 0, mk_desc(200, 3, 1, 1, 40, 3, 0, 12'h105, 5));
		set_slot(2, 1, 1, mk_desc(169, 3, 1, 1, 60, 0, 1, 12'h146, 6));
		set_slot(2, 2, 7, mk_desc(193, 0, 1, 0, 80, 1, 0, 12'h187, 7));
		// sprites wrapping past line 511
		set_slot(3, 0, 20, mk_desc(508, 1, 1, 0, 100, 1, 1, 12'h208, 8));
		set_slot(3, 1, 21, mk_desc(500, 2, 1, 1, 110, 2, 0, 12'h249, 9));
		set_slot(3, 2, 22, mk_desc(490, 1, 1, 0, 120, 0, 0, 12'h28A, 10));
		// spread over lanes and groups with slots out of index order
		set_slot(4, 0, 63, mk_desc(296, 0, 1, 0, 5, 0, 0, 12'hFFF, 15));
		set_slot(4, 1, 3, mk_desc(300, 2, 1, 0, 7, 4, 1, 12'h3CB, 11));
		set_slot(4, 2, 17, mk_desc(290, 1, 1, 1, 300, 5, 0, 12'h40C, 12));
		set_slot(4, 3, 4, mk_desc(299, 7, 1, 0, 450, 6, 1, 12'h44D, 13));
		set_slot(4, 4, 30, mk_desc(250, 7, 1, 1, 511, 7, 1, 12'h48E, 14));
		for (i = 0; i < SLOTS; i++)
			set_slot(5, i, spr_idx[4][i], spr_desc[4][i]);
		// first group and last group on line 0
		set_slot(6, 0, 0, mk_desc(0, 0, 1, 0, 1, 1, 0, 12'h011, 1));
		set_slot(6, 1, 1, mk_desc(511, 0, 1, 1, 2, 2, 1, 12'h052, 2));
		set_slot(6, 2, 2, mk_desc(505, 0, 1, 0, 3, 3, 0, 12'h093, 3));
		set_slot(6, 3, 3, mk_desc(504, 0, 1, 0, 4, 4, 1, 12'h0D4, 4));
		set_slot(6, 4, 62, mk_desc(0, 7, 1, 1, 5, 5, 0, 12'hFC0, 5));
		scen_line = '{106, 58, 200, 5, 300, 300, 0};
		scen_rdy = '{0, 0, 0, 0, 0, 1, 1};
	endtask

	task automatic write_descs(input int s);
		sprite_desc_t d;
		int k;
		int j;
		for (k = 0; k < NUM_SPR; k++)
		begin
			d = desc_for(s, k);
			for (j = 0; j < DESC_WORDS; j++)
			begin
				@(posedge clk);
				sfile_we <= 1'b1;
				sfile_addr <= SFILE_AW'(k * DESC_WORDS + j);
				sfile_data <= word_of(d, j);
			end
		end
		@(posedge clk);
		sfile_we <= 1'b0;
	endtask

	task automatic check_scan(input int s);
		sprite_task_t exp_q [$];
		sprite_task_t t;
		logic hit;
		int k;
		int i;
		int n;
		string tag;
		// expected tasks in ascending sprite index
		for (k = 0; k < NUM_SPR; k++)
			for (i = 0; i < SLOTS; i++)
				if (spr_idx[s][i] == k)
				begin
					hit = model_task(spr_desc[s][i], scen_line[s], t);
					if (hit)
						exp_q.push_back(t);
				end
		check_equal($sformatf("scan %0d task count", s), 32'(got_q.size()), 32'(exp_q.size()));
		n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
		for (i = 0; i < n; i++)
		begin
			tag = $sformatf("scan %0d task %0d", s, i);
			check_equal({tag, " x"}, 32'(got_q[i].x), 32'(exp_q[i].x));
			check_equal({tag, " xs"}, 32'(got_q[i].xs), 32'(exp_q[i].xs));
			check_equal({tag, " xf"}, 32'(got_q[i].xf), 32'(exp_q[i].xf));
			check_equal({tag, " line"}, 32'(got_q[i].line), 32'(exp_q[i].line));
			check_equal({tag, " addr"}, 32'(got_q[i].addr), 32'(exp_q[i].addr));
			check_equal({tag, " pal"}, 32'(got_q[i].pal), 32'(exp_q[i].pal));
		end
		check_equal($sformatf("scan %0d scan_done pulses", s), 32'(done_cnt), 32'd1);
	endtask

	// renderer stub with a ready pattern per table entry
	always @(posedge clk)
	begin
		rnd = $random(seed);
		if (rdy_mode == 0)
			tsr_rdy <= 1'b1;
		else
			tsr_rdy <= rnd[0];
	end

	// outputs sampled mid cycle
	always @(negedge clk)
	begin
		if (tsr_go)
		begin
			check_equal("tsr_rdy with tsr_go", 32'(tsr_rdy), 32'd1);
			check_equal("tsr_go after scan_done", 32'(done_seen), 32'd0);
			mon_t.x = tsr_x;
			mon_t.xs = tsr_xs;
			mon_t.xf = tsr_xf;
			mon_t.line = tsr_line;
			mon_t.addr = tsr_addr;
			mon_t.pal = tsr_pal;
			got_q.push_back(mon_t);
		end
		if (scan_done)
		begin
			done_cnt++;
			done_seen = 1'b1;
		end
	end

	initial
	begin
		cycles = 0;
		while (cycles < LIMIT)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: scan never finished within %0d cycles", LIMIT);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial
	begin
		int s;
		seed = 32'h73da_f241;
		errors = 0;
		checks = 0;
		done_cnt = 0;
		done_seen = 1'b0;
		rdy_mode = 0;
		rst = 1'b1;
		start = 1'b0;
		line = '0;
		sfile_addr = '0;
		sfile_data = '0;
		sfile_we = 1'b0;
		tsr_rdy = 1'b0;
		build_table();
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		for (s = 0; s < N_SCEN; s++)
		begin
			write_descs(s);
			got_q.delete();
			done_cnt = 0;
			done_seen = 1'b0;
			rdy_mode <= scen_rdy[s];
			line <= LINE_W'(scen_line[s]);
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
			while (!done_seen)
				@(posedge clk);
			// quiet time where a late tsr_go or a second scan_done would show
			repeat (12) @(posedge clk);
			check_scan(s);
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
source/ts_geom_pkg.sv
source/ts_task_pkg.sv
source/sprite_lane_if.sv
source/sprite_desc_file.sv
source/sprite_lane.sv
source/sprite_task_issuer.sv
source/sprite_scan_top.sv
dv/tb_sprite_scan.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the sprite scan testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_sprite_scan \
	-Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi
exit 1
